// File: hw/column_page_align.sv
`timescale 1ns/1ps
`include "msg_router_settings.svh"

module column_page_align (
	input  logic        sys_clk,
	input  logic        rst_n_i,
	msg_stage_if.sink   in_bus,
	msg_stage_if.source out_bus
);
	import msg_router_pkg::*;

	frame_t        pa_msg; // frame after page alignment
	frame_t        msg_q;
	pa_shift_vec_t pa_shift_q;
	pa_mode_e      pa_mode_q;
	logic          valid_q;

	//--------------------------------------------------------------------------
	// level-2 rotation across strides, one factor per column
	//--------------------------------------------------------------------------
	always_comb begin
		int amt;
		int src_stride;
		amt        = 0;
		src_stride = 0;
		pa_msg     = in_bus.msg; // bypass keeps the frame as is
		if (in_bus.pa_mode == PA_ROTATE) begin
			for (int c = 0; c < `MR_UNIT_SIZE; c++) begin
				amt = int'(in_bus.pa_shift[c]) % `MR_STRIDE_NUM; // factor may exceed stride count
				for (int k = 0; k < `MR_STRIDE_NUM; k++) begin
					src_stride   = (k + amt) % `MR_STRIDE_NUM;
					pa_msg[k][c] = in_bus.msg[src_stride][c];
				end
			end
		end
	end

	always_ff @(posedge sys_clk) begin
		if (!rst_n_i) begin
			valid_q    <= 1'b0;
			msg_q      <= '0;
			pa_shift_q <= '0;
			pa_mode_q  <= PA_BYPASS;
		end else begin
			valid_q    <= in_bus.valid;
			msg_q      <= pa_msg;
			pa_shift_q <= in_bus.pa_shift;
			pa_mode_q  <= in_bus.pa_mode;
		end
	end

	assign out_bus.valid    = valid_q;
	assign out_bus.msg      = msg_q;
	assign out_bus.pa_shift = pa_shift_q; // forwarded for any later stage
	assign out_bus.pa_mode  = pa_mode_q;

endmodule

// File: hw/ldpc_msg_router.sv
`timescale 1ns/1ps
`include "msg_router_settings.svh"

module ldpc_msg_router (
	input  logic                     sys_clk,
	input  logic                     rst_n_i,
	input  logic                     valid_i,      // frame present on the inputs
	// message buses, stride-major then column then bit
	input  logic [`MR_FRAME_W-1:0]   mem2shift_i,  // extrinsic memory messages
	input  logic [`MR_FRAME_W-1:0]   chan_msg_i,   // channel messages
	input  logic [`MR_FRAME_W-1:0]   mem2mux_i,    // 2nd variable memory messages
	input  logic                     src_sel_i,    // high picks mem2mux_i
	input  logic [`MR_BS_VEC_W-1:0]  bs_shift_i,   // level-1 factors, stride 0 lowest
	input  logic [`MR_PA_VEC_W-1:0]  pa_shift_i,   // level-2 factors, column 0 lowest
	input  logic                     msg_pass_i,   // high rotates at level 2
	output logic [`MR_FRAME_W-1:0]   node_msg_o,
	output logic                     node_valid_o,
	output logic [`MR_FRAME_W-1:0]   ctrl_msg_o,
	output logic [`MR_FRAME_W-1:0]   row_offset_o,
	output logic                     row_valid_o
);
	import msg_router_pkg::*;

	bs_shift_vec_t bs_shift;
	pa_shift_vec_t pa_shift;
	pa_mode_e      pa_mode;
	msg_src_e      src_sel;
	frame_t        chan_frame;
	frame_t        mem_frame;
	frame_t        ctrl_frame;

	msg_stage_if in_if ();   // node path input
	msg_stage_if l1_if ();   // barrel shifter to page aligner
	msg_stage_if node_if (); // node path output
	msg_stage_if row_if ();  // row-offset path output

	//--------------------------------------------------------------------------
	// flat ports to package types
	//--------------------------------------------------------------------------
	assign bs_shift   = bs_shift_i;
	assign pa_shift   = pa_shift_i;
	assign pa_mode    = msg_pass_i ? PA_ROTATE : PA_BYPASS;
	assign src_sel    = src_sel_i ? SRC_MEMORY : SRC_CHANNEL;
	assign chan_frame = chan_msg_i;
	assign mem_frame  = mem2mux_i;

	assign in_if.valid    = valid_i;
	assign in_if.msg      = mem2shift_i;
	assign in_if.pa_shift = pa_shift;
	assign in_if.pa_mode  = pa_mode;

	//--------------------------------------------------------------------------
	// node path, level-1 shift then level-2 alignment
	//--------------------------------------------------------------------------
	stride_barrel_shifter u_l1bs (
		.sys_clk    (sys_clk),
		.rst_n_i    (rst_n_i),
		.in_bus     (in_if),
		.bs_shift_i (bs_shift),
		.out_bus    (l1_if)
	);

	column_page_align u_node_pa (
		.sys_clk (sys_clk),
		.rst_n_i (rst_n_i),
		.in_bus  (l1_if),
		.out_bus (node_if)
	);

	//--------------------------------------------------------------------------
	// row-offset path
	//--------------------------------------------------------------------------
	row_offset_path u_row_path (
		.sys_clk    (sys_clk),
		.rst_n_i    (rst_n_i),
		.chan_msg_i (chan_frame),
		.mem_msg_i  (mem_frame),
		.src_sel_i  (src_sel),
		.valid_i    (valid_i),
		.pa_shift_i (pa_shift),
		.pa_mode_i  (pa_mode),
		.ctrl_msg_o (ctrl_frame),
		.out_bus    (row_if)
	);

	// package types back to flat ports
	assign node_msg_o   = node_if.msg;
	assign node_valid_o = node_if.valid;
	assign ctrl_msg_o   = ctrl_frame;
	assign row_offset_o = row_if.msg;
	assign row_valid_o  = row_if.valid;

endmodule

// File: hw/msg_router_pkg.sv
`include "msg_router_settings.svh"

package msg_router_pkg;

	// message containers, packed so a frame maps straight onto a flat bus
	typedef logic [`MR_QUAN_SIZE-1:0]     msg_t;
	typedef msg_t [`MR_UNIT_SIZE-1:0]     stride_msgs_t; // one stride unit
	typedef stride_msgs_t [`MR_STRIDE_NUM-1:0] frame_t;

	// shift factors
	typedef logic [`MR_BS_SHIFT_W-1:0]    bs_shift_t;
	typedef logic [`MR_PA_SHIFT_W-1:0]    pa_shift_t;
	typedef pa_shift_t [`MR_UNIT_SIZE-1:0]  pa_shift_vec_t; // per column
	typedef bs_shift_t [`MR_STRIDE_NUM-1:0] bs_shift_vec_t; // per stride

	// level-2 page alignment usage
	typedef enum logic {
		PA_BYPASS = 1'b0,
		PA_ROTATE = 1'b1 // message passing permutation
	} pa_mode_e;

	// source feeding the shift control encoder
	typedef enum logic {
		SRC_CHANNEL = 1'b0,
		SRC_MEMORY  = 1'b1
	} msg_src_e;

endpackage

// File: hw/msg_router_settings.svh
`ifndef MSG_ROUTER_SETTINGS_SVH
`define MSG_ROUTER_SETTINGS_SVH

// frame geometry
`define MR_QUAN_SIZE  3 // bits per message
`define MR_STRIDE_NUM 5 // stride units per frame
`define MR_UNIT_SIZE  8 // columns per stride unit

// shift factor widths
`define MR_BS_SHIFT_W ($clog2(`MR_UNIT_SIZE))  // level-1, inside a stride
`define MR_PA_SHIFT_W ($clog2(`MR_STRIDE_NUM)) // level-2, across strides

// flattened port widths
`define MR_FRAME_W    (`MR_STRIDE_NUM * `MR_UNIT_SIZE * `MR_QUAN_SIZE)
`define MR_BS_VEC_W   (`MR_STRIDE_NUM * `MR_BS_SHIFT_W)
`define MR_PA_VEC_W   (`MR_UNIT_SIZE * `MR_PA_SHIFT_W)

`endif

// File: hw/msg_stage_if.sv
`timescale 1ns/1ps

// one frame plus its level-2 factors, handed from stage to stage
interface msg_stage_if;
	import msg_router_pkg::*;

	logic          valid;    // frame present
	frame_t        msg;
	pa_shift_vec_t pa_shift; // level-2 factor per column
	pa_mode_e      pa_mode;

	modport source (
		output valid,
		output msg,
		output pa_shift,
		output pa_mode
	);

	modport sink (
		input valid,
		input msg,
		input pa_shift,
		input pa_mode
	);

endinterface

// File: hw/row_offset_path.sv
`timescale 1ns/1ps

module row_offset_path (
	input  logic                          sys_clk,
	input  logic                          rst_n_i,
	input  msg_router_pkg::frame_t        chan_msg_i, // channel messages
	input  msg_router_pkg::frame_t        mem_msg_i,  // 2nd variable memory messages
	input  msg_router_pkg::msg_src_e      src_sel_i,
	input  logic                          valid_i,
	input  msg_router_pkg::pa_shift_vec_t pa_shift_i,
	input  msg_router_pkg::pa_mode_e      pa_mode_i,
	output msg_router_pkg::frame_t        ctrl_msg_o, // to the shift control encoder
	msg_stage_if.source                   out_bus
);
	import msg_router_pkg::*;

	frame_t sel_msg;

	msg_stage_if sel_bus (); // select logic to page aligner

	//--------------------------------------------------------------------------
	// two-source select
	//--------------------------------------------------------------------------
	always_comb begin
		if (src_sel_i == SRC_MEMORY)
			sel_msg = mem_msg_i;
		else
			sel_msg = chan_msg_i;
	end

	assign ctrl_msg_o = sel_msg; // combinational, same cycle as inputs

	assign sel_bus.valid    = valid_i;
	assign sel_bus.msg      = sel_msg;
	assign sel_bus.pa_shift = pa_shift_i;
	assign sel_bus.pa_mode  = pa_mode_i;

	// row address offset comes out one cycle later
	column_page_align u_row_pa (
		.sys_clk (sys_clk),
		.rst_n_i (rst_n_i),
		.in_bus  (sel_bus),
		.out_bus (out_bus)
	);

endmodule

// File: hw/stride_barrel_shifter.sv
`timescale 1ns/1ps
`include "msg_router_settings.svh"

module stride_barrel_shifter (
	input  logic                          sys_clk,
	input  logic                          rst_n_i,
	msg_stage_if.sink                     in_bus,
	input  msg_router_pkg::bs_shift_vec_t bs_shift_i, // one factor per stride unit
	msg_stage_if.source                   out_bus
);
	import msg_router_pkg::*;

	frame_t        rot_msg;    // level-1 rotated frame
	frame_t        msg_q;
	pa_shift_vec_t pa_shift_q; // level-2 factors travel with their frame
	pa_mode_e      pa_mode_q;
	logic          valid_q;

	//--------------------------------------------------------------------------
	// level-1 rotation inside every stride unit
	//--------------------------------------------------------------------------
	always_comb begin
		int col_idx;
		col_idx = 0;
		for (int s = 0; s < `MR_STRIDE_NUM; s++) begin
			for (int c = 0; c < `MR_UNIT_SIZE; c++) begin
				col_idx = (c + int'(bs_shift_i[s])) % `MR_UNIT_SIZE;
				rot_msg[s][c] = in_bus.msg[s][col_idx];
			end
		end
	end

	//--------------------------------------------------------------------------
	// pipeline register
	//--------------------------------------------------------------------------
	always_ff @(posedge sys_clk) begin
		if (!rst_n_i) begin
			valid_q    <= 1'b0;
			msg_q      <= '0;
			pa_shift_q <= '0;
			pa_mode_q  <= PA_BYPASS;
		end else begin
			valid_q    <= in_bus.valid;
			msg_q      <= rot_msg;
			pa_shift_q <= in_bus.pa_shift; // keep factors aligned for level 2
			pa_mode_q  <= in_bus.pa_mode;
		end
	end

	assign out_bus.valid    = valid_q;
	assign out_bus.msg      = msg_q;
	assign out_bus.pa_shift = pa_shift_q;
	assign out_bus.pa_mode  = pa_mode_q;

endmodule

// File: ldpc_msg_router.f
+incdir+hw
hw/msg_router_pkg.sv
hw/msg_stage_if.sv
hw/stride_barrel_shifter.sv
hw/column_page_align.sv
hw/row_offset_path.sv
hw/ldpc_msg_router.sv
tests/tb_clock_gen.sv
tests/tb_ldpc_msg_router.sv

// File: run_sim.sh
#!/bin/sh
# build the router testbench with Verilator, run it and scan the log
set -e
cd "$(dirname "$0")"

rm -rf obj_dir sim.log
verilator --binary --timing -f ldpc_msg_router.f --top-module tb_ldpc_msg_router -o sim_tb

# the exit status of the run itself is not used, the log decides
./obj_dir/sim_tb > sim.log 2>&1 || true
cat sim.log

if grep -q "TEST FAILED" sim.log; then
	echo "simulation reported a failure"
	exit 1
fi
if ! grep -q "TEST PASSED" sim.log; then
	echo "simulation ended without a result line"
	exit 1
fi
exit 0

// File: tests/tb_clock_gen.sv
`timescale 1ns/1ps

module tb_clock_gen (
	output logic clk_o,
	output logic rst_n_o
);
	localparam int HALF_PERIOD = 20; // 40 ns clock

	initial begin
		clk_o = 1'b0;
		forever #HALF_PERIOD clk_o = ~clk_o;
	end

	// reset held over 5 rising edges, released on a falling edge
	initial begin
		rst_n_o = 1'b0;
		repeat (5) @(posedge clk_o);
		@(negedge clk_o);
		rst_n_o = 1'b1;
	end

endmodule

// File: tests/tb_ldpc_msg_router.sv
`timescale 1ns/1ps
`include "msg_router_settings.svh"

module tb_ldpc_msg_router;

	localparam int QS          = `MR_QUAN_SIZE;
	localparam int SN          = `MR_STRIDE_NUM;
	localparam int US          = `MR_UNIT_SIZE;
	localparam int BSW         = `MR_BS_SHIFT_W;
	localparam int PSW         = `MR_PA_SHIFT_W;
	localparam int FW          = `MR_FRAME_W;
	localparam int NUM_VECTORS = 400;
	localparam int CLK_PERIOD  = 40;

	typedef logic [FW-1:0]           word_t;
	typedef logic [`MR_BS_VEC_W-1:0] bs_vec_t;
	typedef logic [`MR_PA_VEC_W-1:0] pa_vec_t;

	logic    sys_clk;
	logic    rst_n;
	logic    valid_i;
	word_t   mem2shift_i;
	word_t   chan_msg_i;
	word_t   mem2mux_i;
	logic    src_sel_i;
	bs_vec_t bs_shift_i;
	pa_vec_t pa_shift_i;
	logic    msg_pass_i;
	word_t   node_msg_o;
	logic    node_valid_o;
	word_t   ctrl_msg_o;
	word_t   row_offset_o;
	logic    row_valid_o;

	integer  seed;
	word_t   exp_ctrl;
	word_t   node_msg_q[$]; // two-deep line for the node path
	logic    node_vld_q[$];
	word_t   row_msg_q[$];  // one-deep line for the row-offset path
	logic    row_vld_q[$];

	tb_clock_gen u_clk (
		.clk_o   (sys_clk),
		.rst_n_o (rst_n)
	);

	ldpc_msg_router dut (
		.sys_clk      (sys_clk),
		.rst_n_i      (rst_n),
		.valid_i      (valid_i),
		.mem2shift_i  (mem2shift_i),
		.chan_msg_i   (chan_msg_i),
		.mem2mux_i    (mem2mux_i),
		.src_sel_i    (src_sel_i),
		.bs_shift_i   (bs_shift_i),
		.pa_shift_i   (pa_shift_i),
		.msg_pass_i   (msg_pass_i),
		.node_msg_o   (node_msg_o),
		.node_valid_o (node_valid_o),
		.ctrl_msg_o   (ctrl_msg_o),
		.row_offset_o (row_offset_o),
		.row_valid_o  (row_valid_o)
	);

	// ------------------------------------------------------------------------
	// reference model
	// ------------------------------------------------------------------------
	function automatic word_t rotate_in_stride(input word_t frame, input bs_vec_t bs);
		word_t res;
		int    amt;
		int    src_c;
		res = '0;
		for (int s = 0; s < SN; s++) begin
			amt = int'(bs[s*BSW +: BSW]);
			for (int c = 0; c < US; c++) begin
				src_c = (c + amt) % US;
				res[(s*US+c)*QS +: QS] = frame[(s*US+src_c)*QS +: QS];
			end
		end
		return res;
	endfunction

	function automatic word_t rotate_across_strides(input word_t frame, input pa_vec_t pa,
			input logic rotate);
		word_t res;
		int    amt;
		int    src_k;
		res = frame; // bypass leaves the frame alone
		if (rotate) begin
			for (int c = 0; c < US; c++) begin
				amt = int'(pa[c*PSW +: PSW]) % SN;
				for (int k = 0; k < SN; k++) begin
					src_k = (k + amt) % SN;
					res[(k*US+c)*QS +: QS] = frame[(src_k*US+c)*QS +: QS];
				end
			end
		end
		return res;
	endfunction

	function automatic word_t random_frame();
		logic [127:0] tmp;
		tmp = '0;
		for (int w = 0; w < 4; w++)
			tmp[w*32 +: 32] = $random(seed);
		return tmp[FW-1:0];
	endfunction

	task automatic check_value(input string name, input word_t actual, input word_t expected);
		if (actual !== expected) begin
			$display("[ERROR] %s: got %h, expected %h", name, actual, expected);
			$display("TEST FAILED");
			$fatal(1, "stopping on value mismatch");
		end
	endtask

	// ------------------------------------------------------------------------
	// stimulus, driven on the falling edge
	// ------------------------------------------------------------------------
	task automatic apply_vector();
		logic [31:0] r;
		word_t       sel;
		r           = $random(seed);
		valid_i     = (r[1:0] != 2'b00); // roughly one idle cycle in four
		src_sel_i   = r[2];
		msg_pass_i  = r[3];
		bs_shift_i  = bs_vec_t'($random(seed));
		pa_shift_i  = pa_vec_t'($random(seed));
		mem2shift_i = random_frame();
		chan_msg_i  = random_frame();
		mem2mux_i   = random_frame();

		sel      = src_sel_i ? mem2mux_i : chan_msg_i;
		exp_ctrl = sel;
		node_msg_q.push_back(rotate_across_strides(rotate_in_stride(mem2shift_i, bs_shift_i),
			pa_shift_i, msg_pass_i));
		node_vld_q.push_back(valid_i);
		row_msg_q.push_back(rotate_across_strides(sel, pa_shift_i, msg_pass_i));
		row_vld_q.push_back(valid_i);
	endtask

	task automatic check_registered();
		check_value("node_valid_o", word_t'(node_valid_o), word_t'(node_vld_q.pop_front()));
		check_value("node_msg_o", node_msg_o, node_msg_q.pop_front());
		check_value("row_valid_o", word_t'(row_valid_o), word_t'(row_vld_q.pop_front()));
		check_value("row_offset_o", row_offset_o, row_msg_q.pop_front());
	endtask

	initial begin
		seed        = 32'h6202_6e3a;
		valid_i     = 1'b0;
		mem2shift_i = '0;
		chan_msg_i  = '0;
		mem2mux_i   = '0;
		src_sel_i   = 1'b0;
		bs_shift_i  = '0;
		pa_shift_i  = '0;
		msg_pass_i  = 1'b0;
		exp_ctrl    = '0;

		@(posedge rst_n);
		check_value("node_valid_o", word_t'(node_valid_o), '0);
		check_value("row_valid_o", word_t'(row_valid_o), '0);
		check_value("node_msg_o", node_msg_o, '0);
		check_value("row_offset_o", row_offset_o, '0);

		// second stage still holds its reset value for the first check
		node_msg_q.push_back('0);
		node_vld_q.push_back(1'b0);

		for (int i = 0; i < NUM_VECTORS; i++) begin
			apply_vector();
			#1;
			check_value("ctrl_msg_o", ctrl_msg_o, exp_ctrl); // same cycle
			@(negedge sys_clk);
			check_registered();
		end

		$display("TEST PASSED");
		$finish;
	end

	// watchdog
	initial begin
		#((NUM_VECTORS + 5 + 20) * CLK_PERIOD);
		$display("timeout: the test did not finish in the expected time");
		$display("TEST FAILED");
		$fatal(1, "watchdog expired");
	end

endmodule
